// File: hdl/ifu_errdp_pkg.sv
// shared widths, counts and select encodings for the ifu error datapath
// used by every design module and by the testbench

`default_nettype none

package ifu_errdp_pkg;

   // ------------------------------------------------------------------------
   // counts and widths
   // ------------------------------------------------------------------------
   localparam int NTHR       = 4;
   localparam int IC_WAYS    = 4;
   // tag bits per way with the parity bit just above them
   localparam int IC_TAG_SZ  = 28;
   localparam int IC_TAG_ALL = IC_WAYS * (IC_TAG_SZ + 1);
   localparam int INST_W     = 34;
   localparam int PC_W       = 48;
   // error address covers bits 47:4
   localparam int EADR_W     = 44;
   // physical address over bits 39:4
   localparam int PA_W       = 36;
   localparam int ASI_W      = 64;
   localparam int IMASK_W    = 39;

   typedef logic [EADR_W-1:0] eadr_t;

   // ------------------------------------------------------------------------
   // select encodings
   // ------------------------------------------------------------------------
   // per-thread error address update
   typedef enum logic [1:0] {
      EADR_HOLD = 2'd0,
      EADR_MX0  = 2'd1,
      EADR_MX1  = 2'd2,
      EADR_WRT  = 2'd3
   } eadr_op_e;

   // first candidate group from register files, tlb and lsu
   typedef enum logic [1:0] {
      SRC_IRF  = 2'd0,
      SRC_ITLB = 2'd1,
      SRC_FRF  = 2'd2,
      SRC_LSU  = 2'd3
   } eadr_src0_e;

   // second candidate group from fetch and fill addresses
   typedef enum logic [1:0] {
      SRC_PCD1 = 2'd0,
      SRC_L1PA = 2'd1,
      SRC_L2PA = 2'd2,
      SRC_SPU  = 2'd3
   } eadr_src1_e;

   // final read-back source where the last code reads zero
   typedef enum logic [1:0] {
      ASI_ERR  = 2'd0,
      ASI_MISC = 2'd1,
      ASI_ICD  = 2'd2,
      ASI_NONE = 2'd3
   } asi_src_e;

   typedef enum logic [1:0] {
      ERR_EN   = 2'd0,
      ERR_STAT = 2'd1,
      ERR_INJ  = 2'd2,
      ERR_ADDR = 2'd3
   } err_asi_e;

   typedef enum logic [1:0] {
      MISC_ICT   = 2'd0,
      MISC_IMASK = 2'd1,
      MISC_NONE  = 2'd2
   } misc_asi_e;

endpackage

`default_nettype wire

// File: hdl/erd_src_if.sv
// error address candidates, formatted once and shared by all threads
// the source stage drives every field, each thread register reads them

`timescale 1ns/1ps
`default_nettype none

interface erd_src_if;

   // group 0 candidates
   ifu_errdp_pkg::eadr_t irf;
   ifu_errdp_pkg::eadr_t itlb;
   ifu_errdp_pkg::eadr_t frf;
   ifu_errdp_pkg::eadr_t lsu;

   // group 1 candidates
   ifu_errdp_pkg::eadr_t pcd1;
   ifu_errdp_pkg::eadr_t l1pa;
   ifu_errdp_pkg::eadr_t l2pa;
   ifu_errdp_pkg::eadr_t spu;

   // plain levels, new values every cycle
   modport src (
      output irf, itlb, frf, lsu,
      output pcd1, l1pa, l2pa, spu
   );

   modport thr (
      input irf, itlb, frf, lsu,
      input pcd1, l1pa, l2pa, spu
   );

endinterface

`default_nettype wire

// File: hdl/erd_parity_check.sv
// icache tag and instruction parity checks for the fetch error path
// tags are staged into s1 before checking, instruction words are checked
// as they arrive in s1; also builds the tag diagnostic read-back word

`timescale 1ns/1ps
`default_nettype none

module erd_parity_check (
   input  wire                                     rclk,
   input  wire [ifu_errdp_pkg::IC_TAG_ALL-1:0]     ict_tags_f,
   input  wire [3:0]                               icv_valid_f,
   input  wire [1:0]                               asiway_s1,
   input  wire [ifu_errdp_pkg::INST_W-1:0]         topdata_s1,
   input  wire [ifu_errdp_pkg::INST_W-1:0]         fetdata_s1,
   output logic [3:0]                              tagpe_s1,
   output logic                                    nirpe_s1,
   output logic                                    fetpe_s1,
   output logic [34:0]                             tag_asi_data
);

   // staged tags and valid bits
   logic [ifu_errdp_pkg::IC_TAG_ALL-1:0] ictags_s1;
   logic [3:0]                           icv_s1;

   // one slice per way, parity bit on top
   logic [ifu_errdp_pkg::IC_TAG_SZ:0]    way_s1 [ifu_errdp_pkg::IC_WAYS];
   logic [ifu_errdp_pkg::IC_TAG_SZ:0]    asi_way;

   // ------------------------------------------------------------------------
   // f -> s1 staging
   // ------------------------------------------------------------------------
   always_ff @(posedge rclk) begin
      ictags_s1 <= ict_tags_f;
      icv_s1    <= icv_valid_f;
   end

   // ------------------------------------------------------------------------
   // tag parity
   // ------------------------------------------------------------------------
   always_comb begin
      for (int w = 0; w < ifu_errdp_pkg::IC_WAYS; w++) begin
         way_s1[w] = ictags_s1[w*(ifu_errdp_pkg::IC_TAG_SZ+1) +: ifu_errdp_pkg::IC_TAG_SZ+1];
         // even parity over tag plus stored bit
         tagpe_s1[w] = ^way_s1[w];
      end
   end

   // instruction parity, next-inst and fetched word
   assign nirpe_s1 = ^topdata_s1;
   assign fetpe_s1 = ^fetdata_s1;

   // ------------------------------------------------------------------------
   // diagnostic tag read
   // ------------------------------------------------------------------------
   assign asi_way = way_s1[asiway_s1];

   // valid at 34, parity at 32, tag in the low bits
   assign tag_asi_data = {icv_s1[asiway_s1],
                          1'b0,
                          asi_way[ifu_errdp_pkg::IC_TAG_SZ],
                          4'b0,
                          asi_way[ifu_errdp_pkg::IC_TAG_SZ-1:0]};

endmodule

`default_nettype wire

// File: hdl/erd_src_stage.sv
// staging and formatting of the error address sources
// holds the pc / physical address pipe and one-cycle source registers,
// and drives the eight formatted candidates onto the source interface

`timescale 1ns/1ps
`default_nettype none

module erd_src_stage (
   input  wire                                  rclk,
   input  wire [ifu_errdp_pkg::PC_W-1:0]        pc_f,
   input  wire [29:0]                           itlb_paddr_s,
   input  wire [7:0]                            exu_err_reg_m,
   input  wire [7:0]                            exu_err_synd_m,
   input  wire [5:0]                            ffu_err_reg_w2,
   input  wire [13:0]                           ffu_err_synd_w2,
   input  wire [5:0]                            tlu_itlb_index_g,
   input  ifu_errdp_pkg::eadr_t                 lsu_err_addr,
   input  wire [35:0]                           spu_err_addr_w2,
   input  wire [27:0]                           wrtag_f,
   input  wire [7:0]                            wrindex_f,
   erd_src_if.src                               src
);

   // pc pipe, only bits 47:4 matter here
   logic [ifu_errdp_pkg::PC_W-1:4]     pc_s1;
   ifu_errdp_pkg::eadr_t               pc_d1;

   // physical address, tlb page bits joined with page offset from pc
   logic [ifu_errdp_pkg::PA_W-1:0]     paddr_s1;
   logic [ifu_errdp_pkg::PA_W-1:0]     paddr_d1;

   // one-cycle source registers
   logic [7:0]                         irf_reg_w;
   logic [7:0]                         irf_synd_w;
   logic [7:0]                         irf_addr_w;
   logic [5:0]                         itlb_idx_w;
   ifu_errdp_pkg::eadr_t               lsu_addr_w;

   // ------------------------------------------------------------------------
   // registers
   // ------------------------------------------------------------------------
   assign paddr_s1 = {itlb_paddr_s, pc_s1[9:4]};

   always_ff @(posedge rclk) begin
      pc_s1      <= pc_f[ifu_errdp_pkg::PC_W-1:4];
      // stage pc one more cycle for d1 capture
      pc_d1      <= pc_s1;
      paddr_d1   <= paddr_s1;
      irf_reg_w  <= exu_err_reg_m;
      irf_synd_w <= exu_err_synd_m;
      itlb_idx_w <= tlu_itlb_index_g;
      lsu_addr_w <= lsu_err_addr;
   end

   // irf address bit 4 correction
   assign irf_addr_w = {irf_reg_w[7:5],
                        irf_reg_w[4] ^ (irf_reg_w[5] & irf_reg_w[3]),
                        irf_reg_w[3:0]};

   // ------------------------------------------------------------------------
   // candidate formats
   // ------------------------------------------------------------------------
   // integer rf: syndrome above register address
   assign src.irf  = {24'b0, irf_synd_w, 4'b0, irf_addr_w};
   assign src.itlb = {38'b0, itlb_idx_w};

   // float rf: syndrome split in two halves
   assign src.frf  = {17'b0, ffu_err_synd_w2[13:7],
                      1'b0,  ffu_err_synd_w2[6:0],
                      6'b0,  ffu_err_reg_w2};
   assign src.lsu  = lsu_addr_w;

   assign src.pcd1 = pc_d1;
   assign src.l1pa = {8'b0, paddr_d1};
   // l2 fill address from write tag and index
   assign src.l2pa = {8'b0, wrtag_f, wrindex_f};
   assign src.spu  = {8'b0, spu_err_addr_w2};

endmodule

`default_nettype wire

// File: hdl/erd_eadr_thread.sv
// error address register for one thread
// picks a candidate from each group, then holds, captures or takes a write

`timescale 1ns/1ps
`default_nettype none

module erd_eadr_thread (
   input  wire                          rclk,
   erd_src_if.thr                       src,
   input  ifu_errdp_pkg::eadr_op_e      op,
   input  ifu_errdp_pkg::eadr_src0_e    sel0,
   input  ifu_errdp_pkg::eadr_src1_e    sel1,
   input  ifu_errdp_pkg::eadr_t         wr_data,
   output ifu_errdp_pkg::eadr_t         eadr
);

   ifu_errdp_pkg::eadr_t mx0;
   ifu_errdp_pkg::eadr_t mx1;

   // group 0 mux
   always_comb begin
      case (sel0)
         ifu_errdp_pkg::SRC_IRF:  mx0 = src.irf;
         ifu_errdp_pkg::SRC_ITLB: mx0 = src.itlb;
         ifu_errdp_pkg::SRC_FRF:  mx0 = src.frf;
         default:                 mx0 = src.lsu;
      endcase
   end

   // group 1 mux
   always_comb begin
      case (sel1)
         ifu_errdp_pkg::SRC_PCD1: mx1 = src.pcd1;
         ifu_errdp_pkg::SRC_L1PA: mx1 = src.l1pa;
         ifu_errdp_pkg::SRC_L2PA: mx1 = src.l2pa;
         default:                 mx1 = src.spu;
      endcase
   end

   // update, hold keeps last capture
   always_ff @(posedge rclk) begin
      case (op)
         ifu_errdp_pkg::EADR_MX0: eadr <= mx0;
         ifu_errdp_pkg::EADR_MX1: eadr <= mx1;
         // software write from asi store data
         ifu_errdp_pkg::EADR_WRT: eadr <= wr_data;
         default:                 eadr <= eadr;
      endcase
   end

endmodule

`default_nettype wire

// File: hdl/erd_asi_regs.sv
// diagnostic read-back and instruction mask
// error and misc muxes feed the final source mux, whose word is
// registered as the load result one cycle after the select

`timescale 1ns/1ps
`default_nettype none

module erd_asi_regs (
   input  wire                                  rclk,
   input  wire                                  rst,
   input  wire [1:0]                            erren,
   input  wire [22:0]                           errstat,
   input  wire [31:0]                           errinj,
   input  ifu_errdp_pkg::eadr_t                 eadr [ifu_errdp_pkg::NTHR],
   input  wire [1:0]                            asi_thr,
   input  wire [34:0]                           tag_asi_data,
   input  wire [ifu_errdp_pkg::INST_W-1:0]      asidata_s,
   input  wire [38:0]                           asidata_i2,
   input  wire                                  ld_imask,
   input  ifu_errdp_pkg::asi_src_e              asi_src,
   input  ifu_errdp_pkg::err_asi_e              err_sel,
   input  ifu_errdp_pkg::misc_asi_e             misc_sel,
   output logic [ifu_errdp_pkg::IMASK_W-1:0]    imask,
   output logic [ifu_errdp_pkg::ASI_W-1:0]      ldxa_data_w2
);

   logic [ifu_errdp_pkg::ASI_W-1:0] err_asi_data;
   logic [ifu_errdp_pkg::ASI_W-1:0] misc_asi_data;
   logic [ifu_errdp_pkg::ASI_W-1:0] ldxa_data_s;

   // ------------------------------------------------------------------------
   // instruction mask
   // ------------------------------------------------------------------------
   always_ff @(posedge rclk) begin
      if (rst) begin
         imask <= '0;
      end else if (ld_imask) begin
         imask <= asidata_i2;
      end
   end

   // ------------------------------------------------------------------------
   // read-back muxes
   // ------------------------------------------------------------------------
   // error registers, address word for the selected thread
   always_comb begin
      case (err_sel)
         ifu_errdp_pkg::ERR_EN:   err_asi_data = {62'b0, erren};
         ifu_errdp_pkg::ERR_STAT: err_asi_data = {32'b0, errstat, 9'b0};
         ifu_errdp_pkg::ERR_INJ:  err_asi_data = {32'b0, errinj};
         default:                 err_asi_data = {16'b0, eadr[asi_thr], 4'b0};
      endcase
   end

   // tag diagnostic or mask, anything else reads zero
   always_comb begin
      case (misc_sel)
         ifu_errdp_pkg::MISC_ICT:   misc_asi_data = {29'b0, tag_asi_data};
         ifu_errdp_pkg::MISC_IMASK: misc_asi_data = {25'b0, imask};
         default:                   misc_asi_data = '0;
      endcase
   end

   // final source, icache data has its low bit rotated to the top
   always_comb begin
      case (asi_src)
         ifu_errdp_pkg::ASI_ERR:  ldxa_data_s = err_asi_data;
         ifu_errdp_pkg::ASI_MISC: ldxa_data_s = misc_asi_data;
         ifu_errdp_pkg::ASI_ICD:  ldxa_data_s = {30'b0, asidata_s[0], asidata_s[33:1]};
         default:                 ldxa_data_s = '0;
      endcase
   end

   // load result register
   always_ff @(posedge rclk) begin
      ldxa_data_w2 <= ldxa_data_s;
   end

endmodule

`default_nettype wire

// File: hdl/ifu_errdp.sv
// ifu error datapath top: parity checks, error address capture per
// thread and diagnostic read-back; instances and wiring only

`timescale 1ns/1ps
`default_nettype none

module ifu_errdp (
   input  wire                                  rclk,
   input  wire                                  rst,
   input  wire [ifu_errdp_pkg::IC_TAG_ALL-1:0]  ict_tags_f,
   input  wire [3:0]                            icv_valid_f,
   input  wire [1:0]                            asiway_s1,
   input  wire [ifu_errdp_pkg::INST_W-1:0]      topdata_s1,
   input  wire [ifu_errdp_pkg::INST_W-1:0]      fetdata_s1,
   input  wire [ifu_errdp_pkg::PC_W-1:0]        pc_f,
   input  wire [29:0]                           itlb_paddr_s,
   input  wire [7:0]                            exu_err_reg_m,
   input  wire [7:0]                            exu_err_synd_m,
   input  wire [5:0]                            ffu_err_reg_w2,
   input  wire [13:0]                           ffu_err_synd_w2,
   input  wire [5:0]                            tlu_itlb_index_g,
   input  ifu_errdp_pkg::eadr_t                 lsu_err_addr,
   input  wire [35:0]                           spu_err_addr_w2,
   input  wire [27:0]                           wrtag_f,
   input  wire [7:0]                            wrindex_f,
   input  ifu_errdp_pkg::eadr_op_e              eadr_op [ifu_errdp_pkg::NTHR],
   input  ifu_errdp_pkg::eadr_src0_e            eadr_sel0 [ifu_errdp_pkg::NTHR],
   input  ifu_errdp_pkg::eadr_src1_e            eadr_sel1 [ifu_errdp_pkg::NTHR],
   input  wire [47:0]                           asidata_i2,
   input  wire [ifu_errdp_pkg::INST_W-1:0]      asidata_s,
   input  wire [1:0]                            erren,
   input  wire [22:0]                           errstat,
   input  wire [31:0]                           errinj,
   input  wire                                  ld_imask,
   input  wire [1:0]                            asi_thr,
   input  ifu_errdp_pkg::asi_src_e              asi_src,
   input  ifu_errdp_pkg::err_asi_e              err_sel,
   input  ifu_errdp_pkg::misc_asi_e             misc_sel,
   output logic [ifu_errdp_pkg::ASI_W-1:0]      ldxa_data_w2,
   output logic [ifu_errdp_pkg::IMASK_W-1:0]    imask,
   output logic [3:0]                           tagpe_s1,
   output logic                                 nirpe_s1,
   output logic                                 fetpe_s1
);

   logic [34:0]           tag_asi_data;
   ifu_errdp_pkg::eadr_t  eadr [ifu_errdp_pkg::NTHR];

   erd_src_if src_bus ();

   erd_parity_check par_i (
      .rclk, .ict_tags_f, .icv_valid_f, .asiway_s1, .topdata_s1, .fetdata_s1,
      .tagpe_s1, .nirpe_s1, .fetpe_s1, .tag_asi_data
   );

   erd_src_stage src_i (
      .rclk, .pc_f, .itlb_paddr_s, .exu_err_reg_m, .exu_err_synd_m,
      .ffu_err_reg_w2, .ffu_err_synd_w2, .tlu_itlb_index_g, .lsu_err_addr,
      .spu_err_addr_w2, .wrtag_f, .wrindex_f, .src (src_bus.src)
   );

   // one error address register per thread
   for (genvar t = 0; t < ifu_errdp_pkg::NTHR; t++) begin : g_thr
      erd_eadr_thread thr_i (
         .rclk, .src (src_bus.thr), .op (eadr_op[t]), .sel0 (eadr_sel0[t]),
         .sel1 (eadr_sel1[t]), .wr_data (asidata_i2[47:4]), .eadr (eadr[t])
      );
   end

   erd_asi_regs asi_i (
      .rclk, .rst, .erren, .errstat, .errinj, .eadr, .asi_thr, .tag_asi_data,
      .asidata_s, .asidata_i2 (asidata_i2[38:0]), .ld_imask, .asi_src,
      .err_sel, .misc_sel, .imask, .ldxa_data_w2
   );

endmodule

`default_nettype wire

// File: tests/tb_clkgen.sv
// free-running testbench clock, 100 ns period
// starts low so the first rising edge lands at half a period

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
   output logic clk
);

   localparam int HALF_PERIOD = 50;

   initial clk = 1'b0;

   always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

// File: tests/ifu_errdp_props.sv
// concurrent checks on the instruction mask and the load result
// bound into every ifu_errdp instance

`timescale 1ns/1ps
`default_nettype none

module ifu_errdp_props (
   input wire                                 rclk,
   input wire                                 rst,
   input wire                                 ld_imask,
   input wire [ifu_errdp_pkg::IMASK_W-1:0]    imask,
   input ifu_errdp_pkg::asi_src_e             asi_src,
   input wire [ifu_errdp_pkg::ASI_W-1:0]      ldxa_data_w2
);

   // mask is clear one cycle after any reset edge
   imask_rst_a: assert property (@(posedge rclk) rst |=> imask == '0)
      else $error("imask not cleared after reset");

   // no load strobe means no change
   imask_hold_a: assert property (@(posedge rclk) disable iff (rst)
      !ld_imask |=> $stable(imask))
      else $error("imask changed while ld_imask was low");

   // empty read-back slot
   none_zero_a: assert property (@(posedge rclk)
      asi_src == ifu_errdp_pkg::ASI_NONE |=> ldxa_data_w2 == '0)
      else $error("load result not zero after ASI_NONE");

endmodule

bind ifu_errdp ifu_errdp_props props_i (
   .rclk         (rclk),
   .rst          (rst),
   .ld_imask     (ld_imask),
   .imask        (imask),
   .asi_src      (asi_src),
   .ldxa_data_w2 (ldxa_data_w2)
);

`default_nettype wire

// File: tests/tb_ifu_errdp.sv
// testbench for the ifu error datapath
// random fetch, error and asi traffic from a fixed-seed lfsr; every output
// is compared at the falling edge against a cycle model kept in here

`timescale 1ns/1ps
`default_nettype none

module tb_ifu_errdp;

   localparam int CLK_PERIOD   = 100;
   localparam int RESET_CYCLES = 10;
   localparam int N_RST        = 4;
   localparam int N_PAR        = 40;
   localparam int N_EADR       = 200;
   localparam int N_ASI        = 200;
   localparam int N_IMASK      = 100;
   localparam int WATCHDOG_CYCLES =
      RESET_CYCLES + N_RST + N_PAR + N_EADR + N_ASI + N_IMASK + 100;

   // stimulus modes
   // fill writes every thread during reset
   localparam int M_FILL  = 0;
   localparam int M_RST   = 1;
   localparam int M_PAR   = 2;
   localparam int M_EADR  = 3;
   localparam int M_ASI   = 4;
   localparam int M_IMASK = 5;

   wire                                rclk;
   logic                               rst;
   logic [115:0]                       ict_tags_f;
   logic [3:0]                         icv_valid_f;
   logic [1:0]                         asiway_s1, asi_thr, erren;
   logic [33:0]                        topdata_s1, fetdata_s1, asidata_s;
   logic [47:0]                        pc_f, asidata_i2;
   logic [29:0]                        itlb_paddr_s;
   logic [7:0]                         exu_err_reg_m, exu_err_synd_m, wrindex_f;
   logic [5:0]                         ffu_err_reg_w2, tlu_itlb_index_g;
   logic [13:0]                        ffu_err_synd_w2;
   ifu_errdp_pkg::eadr_t               lsu_err_addr;
   logic [35:0]                        spu_err_addr_w2;
   logic [27:0]                        wrtag_f;
   ifu_errdp_pkg::eadr_op_e            eadr_op [ifu_errdp_pkg::NTHR];
   ifu_errdp_pkg::eadr_src0_e          eadr_sel0 [ifu_errdp_pkg::NTHR];
   ifu_errdp_pkg::eadr_src1_e          eadr_sel1 [ifu_errdp_pkg::NTHR];
   logic [22:0]                        errstat;
   logic [31:0]                        errinj;
   logic                               ld_imask;
   ifu_errdp_pkg::asi_src_e            asi_src;
   ifu_errdp_pkg::err_asi_e            err_sel;
   ifu_errdp_pkg::misc_asi_e           misc_sel;
   logic [63:0]                        ldxa_data_w2;
   logic [38:0]                        imask;
   logic [3:0]                         tagpe_s1;
   logic                               nirpe_s1, fetpe_s1;

   // model state named after the stage it mirrors
   logic [47:4]                        m_pc_s1;
   ifu_errdp_pkg::eadr_t               m_pc_d1, m_lsu;
   ifu_errdp_pkg::eadr_t               m_eadr [ifu_errdp_pkg::NTHR];
   logic [35:0]                        m_paddr_d1;
   logic [7:0]                         m_irf_reg, m_irf_synd;
   logic [5:0]                         m_itlb_idx;
   logic [115:0]                       m_tags_s1;
   logic [3:0]                         m_icv_s1;
   logic [38:0]                        m_imask;
   logic [63:0]                        m_ldxa;

   logic [31:0]                        lfsr = 32'h3e06444b;
   int                                 test_errs, total_errs, failed_tests;

   tb_clkgen clkgen_i (.clk(rclk));

   ifu_errdp ifu_errdp_i (.*);

   // ------------------------------------------------------------------------
   // random source
   // ------------------------------------------------------------------------
   // fibonacci lfsr with taps 32 22 2 1 and one step per bit
   function automatic logic [127:0] rand_bits(input int n);
      logic [127:0] r;
      logic         fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r    = {r[126:0], fb};
      end
      return r;
   endfunction

   // ------------------------------------------------------------------------
   // reference model
   // ------------------------------------------------------------------------
   // group 0 candidates with the irf address bit 4 fix
   function automatic ifu_errdp_pkg::eadr_t pick_group0(input ifu_errdp_pkg::eadr_src0_e sel);
      logic [7:0]           a;
      ifu_errdp_pkg::eadr_t r;
      a    = m_irf_reg;
      a[4] = m_irf_reg[4] ^ (m_irf_reg[5] & m_irf_reg[3]);
      r    = '0;
      case (sel)
         ifu_errdp_pkg::SRC_IRF: begin
            r[7:0]   = a;
            r[19:12] = m_irf_synd;
         end
         ifu_errdp_pkg::SRC_ITLB: r[5:0] = m_itlb_idx;
         ifu_errdp_pkg::SRC_FRF: begin
            r[5:0]   = ffu_err_reg_w2;
            r[18:12] = ffu_err_synd_w2[6:0];
            r[26:20] = ffu_err_synd_w2[13:7];
         end
         default:                 r = m_lsu;
      endcase
      return r;
   endfunction

   function automatic ifu_errdp_pkg::eadr_t pick_group1(input ifu_errdp_pkg::eadr_src1_e sel);
      ifu_errdp_pkg::eadr_t r;
      r = '0;
      case (sel)
         ifu_errdp_pkg::SRC_PCD1: r = m_pc_d1;
         ifu_errdp_pkg::SRC_L1PA: r[35:0] = m_paddr_d1;
         ifu_errdp_pkg::SRC_L2PA: begin
            r[7:0]  = wrindex_f;
            r[35:8] = wrtag_f;
         end
         default:                 r[35:0] = spu_err_addr_w2;
      endcase
      return r;
   endfunction

   // word the load result should take at the coming edge
   function automatic logic [63:0] readback_word();
      logic [63:0] r;
      logic [28:0] way;
      r   = '0;
      way = m_tags_s1[asiway_s1*29 +: 29];
      case (asi_src)
         ifu_errdp_pkg::ASI_ERR: begin
            case (err_sel)
               ifu_errdp_pkg::ERR_EN:   r[1:0]  = erren;
               ifu_errdp_pkg::ERR_STAT: r[31:9] = errstat;
               ifu_errdp_pkg::ERR_INJ:  r[31:0] = errinj;
               default:                 r[47:4] = m_eadr[asi_thr];
            endcase
         end
         ifu_errdp_pkg::ASI_MISC: begin
            if (misc_sel == ifu_errdp_pkg::MISC_ICT) begin
               r[34]   = m_icv_s1[asiway_s1];
               r[32]   = way[28];
               r[27:0] = way[27:0];
            end else if (misc_sel == ifu_errdp_pkg::MISC_IMASK) begin
               r[38:0] = m_imask;
            end
         end
         ifu_errdp_pkg::ASI_ICD: begin
            r[33]   = asidata_s[0];
            r[32:0] = asidata_s[33:1];
         end
         default: ;
      endcase
      return r;
   endfunction

   always @(posedge rclk) begin
      m_pc_s1    <= pc_f[47:4];
      m_pc_d1    <= m_pc_s1;
      m_paddr_d1 <= {itlb_paddr_s, m_pc_s1[9:4]};
      m_irf_reg  <= exu_err_reg_m;
      m_irf_synd <= exu_err_synd_m;
      m_itlb_idx <= tlu_itlb_index_g;
      m_lsu      <= lsu_err_addr;
      m_tags_s1  <= ict_tags_f;
      m_icv_s1   <= icv_valid_f;
      for (int t = 0; t < ifu_errdp_pkg::NTHR; t++) begin
         case (eadr_op[t])
            ifu_errdp_pkg::EADR_MX0: m_eadr[t] <= pick_group0(eadr_sel0[t]);
            ifu_errdp_pkg::EADR_MX1: m_eadr[t] <= pick_group1(eadr_sel1[t]);
            ifu_errdp_pkg::EADR_WRT: m_eadr[t] <= asidata_i2[47:4];
            default: ;
         endcase
      end
      if (rst) begin
         m_imask <= '0;
      end else if (ld_imask) begin
         m_imask <= asidata_i2[38:0];
      end
      m_ldxa <= readback_word();
   end

   // ------------------------------------------------------------------------
   // stimulus and checks
   // ------------------------------------------------------------------------
   task automatic drive_inputs(input int mode);
      logic [1:0] r2;
      ict_tags_f       = 116'(rand_bits(116));
      icv_valid_f      = 4'(rand_bits(4));
      asiway_s1        = 2'(rand_bits(2));
      topdata_s1       = 34'(rand_bits(34));
      fetdata_s1       = 34'(rand_bits(34));
      pc_f             = 48'(rand_bits(48));
      itlb_paddr_s     = 30'(rand_bits(30));
      exu_err_reg_m    = 8'(rand_bits(8));
      exu_err_synd_m   = 8'(rand_bits(8));
      ffu_err_reg_w2   = 6'(rand_bits(6));
      ffu_err_synd_w2  = 14'(rand_bits(14));
      tlu_itlb_index_g = 6'(rand_bits(6));
      lsu_err_addr     = 44'(rand_bits(44));
      spu_err_addr_w2  = 36'(rand_bits(36));
      wrtag_f          = 28'(rand_bits(28));
      wrindex_f        = 8'(rand_bits(8));
      asidata_i2       = 48'(rand_bits(48));
      asidata_s        = 34'(rand_bits(34));
      erren            = 2'(rand_bits(2));
      errstat          = 23'(rand_bits(23));
      errinj           = 32'(rand_bits(32));
      asi_thr          = 2'(rand_bits(2));
      ld_imask         = 1'b0;
      asi_src          = ifu_errdp_pkg::ASI_NONE;
      err_sel          = ifu_errdp_pkg::ERR_EN;
      misc_sel         = ifu_errdp_pkg::MISC_NONE;
      for (int t = 0; t < ifu_errdp_pkg::NTHR; t++) begin
         eadr_sel0[t] = ifu_errdp_pkg::eadr_src0_e'(2'(rand_bits(2)));
         eadr_sel1[t] = ifu_errdp_pkg::eadr_src1_e'(2'(rand_bits(2)));
         if (mode == M_FILL)
            eadr_op[t] = ifu_errdp_pkg::EADR_WRT;
         else if (mode == M_EADR)
            eadr_op[t] = ifu_errdp_pkg::eadr_op_e'(2'(rand_bits(2)));
         else
            eadr_op[t] = ifu_errdp_pkg::EADR_HOLD;
      end
      case (mode)
         M_RST, M_IMASK: begin
            asi_src  = ifu_errdp_pkg::ASI_MISC;
            misc_sel = ifu_errdp_pkg::MISC_IMASK;
            // load strobe about one cycle in four
            ld_imask = (mode == M_IMASK) && (2'(rand_bits(2)) == 2'd0);
         end
         M_EADR: begin
            asi_src = ifu_errdp_pkg::ASI_ERR;
            err_sel = ifu_errdp_pkg::ERR_ADDR;
         end
         M_ASI: begin
            asi_src = ifu_errdp_pkg::asi_src_e'(2'(rand_bits(2)));
            err_sel = ifu_errdp_pkg::err_asi_e'(2'(rand_bits(2)));
            r2      = 2'(rand_bits(2));
            // unused misc code folds onto the tag read
            if (r2 == 2'd3)
               r2 = 2'd0;
            misc_sel = ifu_errdp_pkg::misc_asi_e'(r2);
         end
         default: ;
      endcase
   endtask

   task automatic report_mismatch(input string name, input string sig,
                                  input logic [63:0] exp, input logic [63:0] act);
      $display("FAILED %s %s expected %h actual %h", name, sig, exp, act);
      test_errs++;
   endtask

   task automatic check_outputs(input string name, input int mode);
      logic [3:0] exp_pe;
      for (int w = 0; w < ifu_errdp_pkg::IC_WAYS; w++)
         exp_pe[w] = ^m_tags_s1[w*29 +: 29];
      if (tagpe_s1 !== exp_pe)
         report_mismatch(name, "tagpe_s1", 64'(exp_pe), 64'(tagpe_s1));
      if (nirpe_s1 !== ^topdata_s1)
         report_mismatch(name, "nirpe_s1", 64'(^topdata_s1), 64'(nirpe_s1));
      if (fetpe_s1 !== ^fetdata_s1)
         report_mismatch(name, "fetpe_s1", 64'(^fetdata_s1), 64'(fetpe_s1));
      if (imask !== m_imask)
         report_mismatch(name, "imask", 64'(m_imask), 64'(imask));
      if (ldxa_data_w2 !== m_ldxa)
         report_mismatch(name, "ldxa_data_w2", m_ldxa, ldxa_data_w2);
      // right after reset both must read plain zero
      if (mode == M_RST && imask !== '0)
         report_mismatch(name, "imask", 64'd0, 64'(imask));
      if (mode == M_RST && ldxa_data_w2 !== '0)
         report_mismatch(name, "ldxa_data_w2", 64'd0, ldxa_data_w2);
   endtask

   task automatic run_test(input string name, input int mode, input int n);
      test_errs = 0;
      for (int i = 0; i < n; i++) begin
         drive_inputs(mode);
         @(negedge rclk);
         check_outputs(name, mode);
      end
      $display("test %-8s %0d cycles, %0d errors", name, n, test_errs);
      total_errs += test_errs;
      if (test_errs != 0)
         failed_tests++;
   endtask

   initial begin
      total_errs   = 0;
      failed_tests = 0;
      rst          = 1'b1;
      drive_inputs(M_FILL);
      // every thread register takes a write while reset is held
      repeat (RESET_CYCLES) begin
         @(negedge rclk);
         drive_inputs(M_FILL);
      end
      rst = 1'b0;
      run_test("reset", M_RST, N_RST);
      run_test("parity", M_PAR, N_PAR);
      run_test("eadr", M_EADR, N_EADR);
      run_test("asi", M_ASI, N_ASI);
      run_test("imask", M_IMASK, N_IMASK);
      $display("tests 5, failed tests %0d, failed checks %0d", failed_tests, total_errs);
      if (total_errs == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

   // watchdog over the whole run
   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired, run did not end within %0d cycles", WATCHDOG_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
hdl/ifu_errdp_pkg.sv
hdl/erd_src_if.sv
hdl/erd_parity_check.sv
hdl/erd_src_stage.sv
hdl/erd_eadr_thread.sv
hdl/erd_asi_regs.sv
hdl/ifu_errdp.sv
tests/tb_clkgen.sv
tests/ifu_errdp_props.sv
tests/tb_ifu_errdp.sv

// File: run.sh
#!/bin/sh
# build the testbench with verilator, run it, and check the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_ifu_errdp \
   -f project.f -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -q "ALL TESTS PASSED" sim.log; then
   exit 0
fi
exit 1
